// ==== ex_pkg.sv ====
package ex_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int XLEN    = 32;
  localparam int SHAMT_W = 5;

  // --------------------
  // encodings
  // --------------------
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_OR,
    OP_XOR,
    OP_NOR,
    OP_AND,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_LUI,
    OP_PASS_A,
    OP_PASS_B
  } alu_op_t;

  typedef enum logic [1:0] {
    FWD_NONE,   // register file value
    FWD_EXMEM,
    FWD_MEMWB
  } fwd_sel_t;

  typedef enum logic {
    RES_ALU,
    RES_SET
  } res_unit_t;

  // --------------------
  // bundles
  // --------------------
  typedef struct packed {
    logic [XLEN-1:0]    a_val;
    logic [XLEN-1:0]    b_val;
    logic [XLEN-1:0]    imm;
    fwd_sel_t           a_fwd;
    fwd_sel_t           b_fwd;
    logic               imm_valid;
    logic [SHAMT_W-1:0] shamt;
    logic               shift_var;   // sllv, srlv and srav take the amount from A
    alu_op_t            alu_op;
    res_unit_t          res_unit;
    logic               set_unsigned;
  } ex_req_t;

  typedef struct packed {
    logic [XLEN-1:0] ex_mem;
    logic [XLEN-1:0] mem_wb;
  } ex_bypass_t;

  typedef struct packed {
    logic [XLEN-1:0]    a;
    logic [XLEN-1:0]    b;
    logic [XLEN-1:0]    store_data;  // forwarded B before the immediate is applied
    logic [SHAMT_W-1:0] shamt;
  } ex_operands_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] store_data;
  } ex_resp_t;

endpackage

// ==== ex_operand_mux.sv ====
module ex_operand_mux import ex_pkg::*; (
  input  ex_req_t      request,
  input  ex_bypass_t   bypass,
  output ex_operands_t operands
);

  logic [XLEN-1:0] a_fwd_val;
  logic [XLEN-1:0] b_fwd_val;

  // pick one source word according to the forwarding select
  function automatic logic [XLEN-1:0] resolve(
    input fwd_sel_t        sel,
    input logic [XLEN-1:0] reg_val,
    input ex_bypass_t      byp
  );
    logic [XLEN-1:0] val;
    case (sel)
      FWD_EXMEM: val = byp.ex_mem;
      FWD_MEMWB: val = byp.mem_wb;
      default:   val = reg_val;
    endcase
    return val;
  endfunction

  assign a_fwd_val = resolve(request.a_fwd, request.a_val, bypass);
  assign b_fwd_val = resolve(request.b_fwd, request.b_val, bypass);

  always_comb begin
    operands.a          = a_fwd_val;
    operands.b          = request.imm_valid ? request.imm : b_fwd_val;
    operands.store_data = b_fwd_val;  // stores always write the register operand

    // variable shifts use the low bits of A
    if (request.shift_var) begin
      operands.shamt = a_fwd_val[SHAMT_W-1:0];
    end else begin
      operands.shamt = request.shamt;
    end
  end

endmodule

// ==== ex_alu.sv ====
module ex_alu import ex_pkg::*; (
  input  ex_operands_t    operands,
  input  alu_op_t         alu_op,
  output logic [XLEN-1:0] alu_result
);

  logic [XLEN-1:0]    a;
  logic [XLEN-1:0]    b;
  logic [SHAMT_W-1:0] sh;

  assign a  = operands.a;
  assign b  = operands.b;
  assign sh = operands.shamt;

  always_comb begin
    alu_result = '0;

    case (alu_op)
      // --------------------
      // arithmetic and logic
      // --------------------
      OP_ADD: begin
        alu_result = a + b;  // wraps and drops the carry out
      end
      OP_SUB: begin
        alu_result = a - b;
      end
      OP_OR: begin
        alu_result = a | b;
      end
      OP_XOR: begin
        alu_result = a ^ b;
      end
      OP_NOR: begin
        alu_result = ~(a | b);
      end
      OP_AND: begin
        alu_result = a & b;
      end

      // --------------------
      // shifts
      // --------------------
      OP_SLL: begin
        alu_result = b << sh;
      end
      OP_SRL: begin
        alu_result = b >> sh;
      end
      OP_SRA: begin
        alu_result = $signed(b) >>> sh;  // sign bit fills from the top
      end

      // --------------------
      // moves
      // --------------------
      OP_LUI: begin
        alu_result = {b[XLEN/2-1:0], {(XLEN/2){1'b0}}};
      end
      OP_PASS_A: begin
        alu_result = a;
      end
      OP_PASS_B: begin
        alu_result = b;
      end

      default: begin
        alu_result = '0;
      end
    endcase
  end

endmodule

// ==== ex_set_unit.sv ====
module ex_set_unit import ex_pkg::*; (
  input  ex_operands_t    operands,
  input  logic            set_unsigned,
  output logic [XLEN-1:0] set_result
);

  logic [XLEN-1:0] a_cmp;
  logic [XLEN-1:0] b_cmp;
  logic [XLEN:0]   diff;
  logic            less;

  // flipping both sign bits turns a signed compare into an unsigned one
  always_comb begin
    a_cmp = operands.a;
    b_cmp = operands.b;
    if (!set_unsigned) begin
      a_cmp[XLEN-1] = ~operands.a[XLEN-1];
      b_cmp[XLEN-1] = ~operands.b[XLEN-1];
    end
  end

  // borrow out of a - b means a is below b
  assign diff = {1'b0, a_cmp} - {1'b0, b_cmp};
  assign less = diff[XLEN];

  assign set_result = {{(XLEN-1){1'b0}}, less};

endmodule

// ==== ex_result_stage.sv ====
module ex_result_stage import ex_pkg::*; (
  input  logic            clock,
  input  logic            rst,
  input  logic            req,
  input  logic [XLEN-1:0] alu_result,
  input  logic [XLEN-1:0] set_result,
  input  res_unit_t       res_unit,
  input  logic [XLEN-1:0] store_data,
  output logic            ack,
  output ex_resp_t        response
);

  typedef enum logic {
    ST_IDLE,
    ST_ACK
  } state_t;

  state_t          state;
  state_t          state_next;
  logic [XLEN-1:0] selected;
  logic            capture;

  assign selected = (res_unit == RES_SET) ? set_result : alu_result;

  // --------------------
  // handshake FSM
  // --------------------
  always_comb begin
    state_next = state;
    capture    = 1'b0;

    case (state)
      ST_IDLE: begin
        if (req) begin
          state_next = ST_ACK;
          capture    = 1'b1;  // request is stable while req is high
        end
      end
      ST_ACK: begin
        // hold until the requester drops req
        if (!req) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // --------------------
  // output register
  // --------------------
  always_ff @(posedge clock) begin
    if (rst) begin
      response <= '0;
    end else if (capture) begin
      response.result     <= selected;
      response.store_data <= store_data;
    end
  end

  assign ack = (state == ST_ACK);

endmodule

// ==== ex_stage.sv ====
module ex_stage import ex_pkg::*; (
  input  logic       clock,
  input  logic       rst,
  input  logic       req,
  input  ex_req_t    request,
  input  ex_bypass_t bypass,
  output logic       ack,
  output ex_resp_t   response
);

  ex_operands_t    operands;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] set_result;

  // operand selection with bypass and immediate
  ex_operand_mux u_operand_mux (
    .request  (request),
    .bypass   (bypass),
    .operands (operands)
  );

  // --------------------
  // the two units run side by side on the same operands
  // --------------------
  ex_alu u_alu (
    .operands   (operands),
    .alu_op     (request.alu_op),
    .alu_result (alu_result)
  );

  ex_set_unit u_set_unit (
    .operands     (operands),
    .set_unsigned (request.set_unsigned),
    .set_result   (set_result)
  );

  ex_result_stage u_result_stage (
    .clock      (clock),
    .rst        (rst),
    .req        (req),
    .alu_result (alu_result),
    .set_result (set_result),
    .res_unit   (request.res_unit),
    .store_data (operands.store_data),
    .ack        (ack),
    .response   (response)
  );

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int PERIOD = 40
) (
  output logic clock
);

  // starts low so the first edge is a rising one
  initial begin
    clock = 1'b0;
    forever begin
      #(PERIOD / 2) clock = ~clock;
    end
  end

endmodule

// ==== tb_ex_stage.sv ====
module tb_ex_stage import ex_pkg::*; ();

  localparam int PERIOD      = 40;
  localparam int RST_CYCLES  = 16;
  localparam int N_TXN       = 88;
  localparam int WATCHDOG_T  = (N_TXN * 20 + RST_CYCLES) * PERIOD;

  logic       clock;
  logic       rst;
  logic       req;
  ex_req_t    request;
  ex_bypass_t bypass;
  logic       ack;
  ex_resp_t   response;

  tb_clock_gen #(.PERIOD(PERIOD)) u_clock_gen (.clock(clock));

  ex_stage u_ex_stage (
    .clock    (clock),
    .rst      (rst),
    .req      (req),
    .request  (request),
    .bypass   (bypass),
    .ack      (ack),
    .response (response)
  );

  task automatic value_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("ERROR %s: expected %h, actual %h", name, exp, got);
    $display(">>> FAIL");
    $fatal(1, "value mismatch");
  endtask

  task automatic protocol_fault(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "handshake or check failure");
  endtask

  // --------------------
  // handshake checks
  // --------------------
  assert property (@(posedge clock) disable iff (rst) (req && !ack) |=> ack)
    else protocol_fault("ack did not rise one cycle after req was sampled high");
  assert property (@(posedge clock) disable iff (rst) (ack && req) |=> ack)
    else protocol_fault("ack fell while req was still high");
  assert property (@(posedge clock) disable iff (rst) (ack && !req) |=> !ack)
    else protocol_fault("ack did not fall one cycle after req was sampled low");
  assert property (@(posedge clock) disable iff (rst) ack |=> $stable(response))
    else protocol_fault("response changed while ack was high");

  // --------------------
  // reference model
  // --------------------
  function automatic logic [31:0] pick_source(input fwd_sel_t sel, input logic [31:0] reg_val,
                                              input ex_bypass_t byp);
    if (sel == FWD_EXMEM) return byp.ex_mem;
    if (sel == FWD_MEMWB) return byp.mem_wb;
    return reg_val;
  endfunction

  function automatic ex_resp_t expect_resp(input ex_req_t r, input ex_bypass_t byp);
    ex_resp_t    exp;
    logic [31:0] a;
    logic [31:0] b_fwd;
    logic [31:0] b;
    logic [31:0] alu;
    logic [4:0]  sh;
    logic        lt;
    a     = pick_source(r.a_fwd, r.a_val, byp);
    b_fwd = pick_source(r.b_fwd, r.b_val, byp);
    b     = r.imm_valid ? r.imm : b_fwd;
    sh    = r.shift_var ? a[4:0] : r.shamt;
    case (r.alu_op)
      OP_ADD:    alu = a + b;
      OP_SUB:    alu = a + ~b + 32'd1;
      OP_OR:     alu = a | b;
      OP_XOR:    alu = a ^ b;
      OP_NOR:    alu = ~a & ~b;
      OP_AND:    alu = a & b;
      OP_SLL:    alu = b << sh;
      OP_SRL:    alu = b >> sh;
      OP_SRA:    alu = (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      OP_LUI:    alu = {b[15:0], 16'h0000};
      OP_PASS_A: alu = a;
      OP_PASS_B: alu = b;
      default:   alu = 32'h0;
    endcase
    lt = r.set_unsigned ? (a < b) : ($signed(a) < $signed(b));
    exp.result     = (r.res_unit == RES_SET) ? {31'h0, lt} : alu;
    exp.store_data = b_fwd;
    return exp;
  endfunction

  function automatic ex_bypass_t random_bypass();
    ex_bypass_t byp;
    byp.ex_mem = $urandom();
    byp.mem_wb = $urandom();
    return byp;
  endfunction

  // plain register operands with imm and shamt random but unused unless enabled
  function automatic ex_req_t base_req(input alu_op_t op, input logic [31:0] a,
                                       input logic [31:0] b);
    ex_req_t r;
    r.a_val        = a;
    r.b_val        = b;
    r.imm          = $urandom();
    r.a_fwd        = FWD_NONE;
    r.b_fwd        = FWD_NONE;
    r.imm_valid    = 1'b0;
    r.shamt        = $urandom_range(31, 0);
    r.shift_var    = 1'b0;
    r.alu_op       = op;
    r.res_unit     = RES_ALU;
    r.set_unsigned = 1'b0;
    return r;
  endfunction

  // --------------------
  // transactions
  // --------------------
  task automatic run_txn(input string name, input ex_req_t r, input ex_bypass_t byp,
                         output ex_resp_t got);
    ex_resp_t     exp;
    int unsigned  hold;
    logic [127:0] noise;
    exp     = expect_resp(r, byp);
    hold    = $urandom_range(3, 0);
    request = r;
    bypass  = byp;
    req     = 1'b1;
    @(negedge clock);
    while (!ack) @(negedge clock);
    got = response;
    assert (got.result == exp.result)
      else value_mismatch({name, " result"}, exp.result, got.result);
    assert (got.store_data == exp.store_data)
      else value_mismatch({name, " store_data"}, exp.store_data, got.store_data);
    repeat (hold) begin
      @(negedge clock);
      assert (ack) else protocol_fault("ack dropped while the requester held req high");
    end
    req     = 1'b0;
    noise   = {$urandom(), $urandom(), $urandom(), $urandom()};
    request = noise[$bits(ex_req_t)-1:0];  // inputs may change once req is low
    bypass  = random_bypass();
    @(negedge clock);
    while (ack) @(negedge clock);
  endtask

  task automatic run_set_pair(input string name, input logic [31:0] a, input logic [31:0] b);
    ex_req_t  r;
    ex_resp_t got_s;
    ex_resp_t got_u;
    r          = base_req(OP_ADD, a, b);
    r.res_unit = RES_SET;
    run_txn({name, " signed"}, r, random_bypass(), got_s);
    r.set_unsigned = 1'b1;
    run_txn({name, " unsigned"}, r, random_bypass(), got_u);
    if (a[31] != b[31]) begin
      assert (got_s.result != got_u.result)
        else protocol_fault({name, ": signed and unsigned results agree although signs differ"});
    end
  endtask

  task automatic test_alu_logic();
    alu_op_t  ops[6] = '{OP_ADD, OP_SUB, OP_OR, OP_XOR, OP_NOR, OP_AND};
    ex_resp_t got;
    foreach (ops[i]) begin
      for (int k = 0; k < 4; k++) begin
        run_txn($sformatf("alu %s #%0d", ops[i].name(), k),
                base_req(ops[i], $urandom(), $urandom()), random_bypass(), got);
      end
    end
  endtask

  task automatic test_shifts_moves();
    alu_op_t  ops[3] = '{OP_SLL, OP_SRL, OP_SRA};
    alu_op_t  moves[3] = '{OP_LUI, OP_PASS_A, OP_PASS_B};
    ex_req_t  r;
    ex_resp_t got;
    foreach (ops[i]) begin
      for (int v = 0; v < 2; v++) begin
        for (int k = 0; k < 3; k++) begin
          r           = base_req(ops[i], $urandom(), $urandom());
          r.shift_var = v[0];
          if (k == 0) r.b_val[31] = 1'b1;  // negative B shows the sign fill
          run_txn($sformatf("shift %s var=%0d #%0d", ops[i].name(), v, k), r,
                  random_bypass(), got);
        end
      end
    end
    foreach (moves[i]) begin
      for (int k = 0; k < 2; k++) begin
        run_txn($sformatf("move %s #%0d", moves[i].name(), k),
                base_req(moves[i], $urandom(), $urandom()), random_bypass(), got);
      end
    end
  endtask

  task automatic test_forwarding();
    ex_req_t  r;
    ex_resp_t got;
    for (int af = 0; af < 3; af++) begin
      for (int bf = 0; bf < 3; bf++) begin
        r       = base_req(OP_SUB, $urandom(), $urandom());  // sub keeps A and B apart
        r.a_fwd = fwd_sel_t'(af);
        r.b_fwd = fwd_sel_t'(bf);
        run_txn($sformatf("fwd a=%0d b=%0d", af, bf), r, random_bypass(), got);
      end
    end
    for (int bf = 0; bf < 3; bf++) begin
      r           = base_req(OP_ADD, $urandom(), $urandom());
      r.b_fwd     = fwd_sel_t'(bf);
      r.imm_valid = 1'b1;
      run_txn($sformatf("imm b=%0d", bf), r, random_bypass(), got);
    end
  endtask

  task automatic test_set_unit();
    logic [31:0] ca[6] = '{32'd5, 32'hffff_ffff, 32'd1, 32'h8000_0000, 32'd0, 32'h8000_0000};
    logic [31:0] cb[6] = '{32'd5, 32'd1, 32'hffff_ffff, 32'd0, 32'h8000_0000, 32'h7fff_ffff};
    foreach (ca[i]) begin
      run_set_pair($sformatf("set corner #%0d", i), ca[i], cb[i]);
    end
    for (int k = 0; k < 8; k++) begin
      run_set_pair($sformatf("set random #%0d", k), $urandom(), $urandom());
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    rst       = 1'b1;
    req       = 1'b0;
    request   = '0;
    bypass    = '0;
    void'($urandom(59953));
    repeat (RST_CYCLES) @(negedge clock);
    rst = 1'b0;
    assert (!ack) else protocol_fault("ack is not low after reset");
    assert (response == '0) else protocol_fault("response is not zero after reset");

    test_alu_logic();
    test_shifts_moves();
    test_forwarding();
    test_set_unit();

    $display(">>> PASS");
    $finish;
  end

  initial begin
    #(WATCHDOG_T);
    $display("watchdog expired before the tests finished");
    $display(">>> FAIL");
    $fatal(1, "timeout");
  end

endmodule

// ==== ex_stage.f ====
ex_pkg.sv
ex_operand_mux.sv
ex_alu.sv
ex_set_unit.sv
ex_result_stage.sv
ex_stage.sv
tb_clock_gen.sv
tb_ex_stage.sv
